//--- vlog.f
+incdir+verilog
verilog/rv_decode_pkg.sv
verilog/inst_fields.sv
verilog/inst_classifier.sv
verilog/operand_mux.sv
verilog/decode_stage.sv
tests/decode_stage_assertions.sv
tests/decode_stage_tb.sv

//--- tests/decode_stage_tb.sv
/* Decode stage testbench
   random instruction stream checked against a reference decode model */
`timescale 1ns/1ns
`include "rv_decode_macros.svh"

module decode_stage_tb;

  localparam int NUM_INSTS      = 2000;
  localparam int RESET_CYCLES   = 8;
  localparam int CLK_PERIOD     = 40;
  localparam int TIMEOUT_CYCLES = NUM_INSTS + RESET_CYCLES + 50;

  logic                       clk;
  logic                       rst;
  logic                       ena;
  logic [31:0]                inst;
  logic [63:0]                pc;
  logic [63:0]                rs1_data;
  logic [63:0]                rs2_data;
  logic                       valid;
  rv_decode_pkg::decode_out_t dec;

  logic                       exp_valid;
  rv_decode_pkg::decode_out_t exp_dec;
  logic [63:0]                lcg_state;
  int                         errors;

  decode_stage i_decode_stage (
    .clk        (clk),
    .rst        (rst),
    .i_ena      (ena),
    .i_inst     (inst),
    .i_pc       (pc),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_valid    (valid),
    .o_dec      (dec)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // 64-bit lcg, upper half has the better bits
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcg_state[63:32];
  endfunction

  function automatic logic [6:0] kept_opcode(input logic [31:0] idx);
    case (idx)
      0: return `OPC_LUI;
      1: return `OPC_AUIPC;
      2: return `OPC_JAL;
      3: return `OPC_JALR;
      4: return `OPC_BRANCH;
      5: return `OPC_LOAD;
      6: return `OPC_STORE;
      7: return `OPC_OP_IMM;
      8: return `OPC_OP;
      9: return `OPC_OP_IMM32;
      10: return `OPC_OP32;
      default: return `OPC_SYSTEM;
    endcase
  endfunction

  function automatic rv_decode_pkg::decode_out_t model_decode(
    input logic [31:0] word,
    input logic [63:0] cur_pc,
    input logic [63:0] rs1_val,
    input logic [63:0] rs2_val
  );
    rv_decode_pkg::decode_out_t d;
    rv_decode_pkg::inst_fmt_e   fmt;
    logic [2:0]                 f3;
    logic                       shift_imm;
    logic                       is_load;
    logic                       is_jalr;
    logic [63:0]                imm_i;
    logic [63:0]                imm_s;
    logic [63:0]                imm_b;
    logic [63:0]                imm_u;
    logic [63:0]                imm_j;
    f3        = word[14:12];
    fmt       = rv_decode_pkg::FMT_NONE;
    shift_imm = 1'b0;
    is_load   = 1'b0;
    is_jalr   = 1'b0;
    imm_i = {{52{word[31]}}, word[31:20]};
    imm_s = {{52{word[31]}}, word[31:25], word[11:7]};
    imm_b = {{51{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    imm_u = {{32{word[31]}}, word[31:12], 12'b0};
    imm_j = {{43{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
    case (word[6:0])
      `OPC_OP: fmt = rv_decode_pkg::FMT_R;
      `OPC_OP32: if (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5) fmt = rv_decode_pkg::FMT_R;
      `OPC_OP_IMM: begin
        fmt       = rv_decode_pkg::FMT_I;
        shift_imm = (f3 == 3'd1 || f3 == 3'd5);
      end
      `OPC_OP_IMM32: begin
        if (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5) fmt = rv_decode_pkg::FMT_I;
        shift_imm = (f3 == 3'd1 || f3 == 3'd5);
      end
      `OPC_LOAD: begin
        is_load = (f3 != 3'd7);
        if (is_load) fmt = rv_decode_pkg::FMT_I;
      end
      `OPC_JALR: begin
        is_jalr = (f3 == 3'd0);
        if (is_jalr) fmt = rv_decode_pkg::FMT_I;
      end
      `OPC_STORE: if (f3 < 3'd4) fmt = rv_decode_pkg::FMT_S;
      `OPC_BRANCH: if (f3 != 3'd2 && f3 != 3'd3) fmt = rv_decode_pkg::FMT_B;
      `OPC_LUI, `OPC_AUIPC: fmt = rv_decode_pkg::FMT_U;
      `OPC_JAL: fmt = rv_decode_pkg::FMT_J;
      `OPC_SYSTEM: begin
        if (f3 >= 3'd1 && f3 <= 3'd3) fmt = rv_decode_pkg::FMT_I;
        else if (f3 >= 3'd5) fmt = rv_decode_pkg::FMT_CSRI;
      end
      default: fmt = rv_decode_pkg::FMT_NONE;
    endcase

    d = '0;
    d.fmt     = fmt;
    d.skipcmt = (word == 32'h0000007b);
    d.rs1_ren = (fmt == rv_decode_pkg::FMT_R) || (fmt == rv_decode_pkg::FMT_I) ||
                (fmt == rv_decode_pkg::FMT_S) || (fmt == rv_decode_pkg::FMT_B);
    d.rs2_ren = (fmt == rv_decode_pkg::FMT_R) || (fmt == rv_decode_pkg::FMT_S) ||
                (fmt == rv_decode_pkg::FMT_B);
    d.rd_wen  = (fmt == rv_decode_pkg::FMT_R) || (fmt == rv_decode_pkg::FMT_I) ||
                (fmt == rv_decode_pkg::FMT_U) || (fmt == rv_decode_pkg::FMT_J) ||
                (fmt == rv_decode_pkg::FMT_CSRI);
    d.rs1 = d.rs1_ren ? word[19:15] : 5'd0;
    d.rs2 = d.rs2_ren ? word[24:20] : 5'd0;
    d.rd  = d.rd_wen ? word[11:7] : 5'd0;

    case (fmt)
      rv_decode_pkg::FMT_R, rv_decode_pkg::FMT_S, rv_decode_pkg::FMT_B: begin
        d.op1 = rs1_val;
        d.op2 = rs2_val;
      end
      rv_decode_pkg::FMT_I: begin
        d.op1 = rs1_val;
        d.op2 = shift_imm ? {58'd0, word[25:20]} : imm_i;
      end
      rv_decode_pkg::FMT_U: begin
        d.op1 = imm_u;
        d.op2 = cur_pc;
      end
      rv_decode_pkg::FMT_J: begin
        d.op1 = cur_pc;
        d.op2 = 64'd4;
      end
      rv_decode_pkg::FMT_CSRI: d.op1 = {59'd0, word[19:15]};
      default: d.op1 = 64'd0;
    endcase

    case (fmt)
      rv_decode_pkg::FMT_B: d.op3 = cur_pc + imm_b;
      rv_decode_pkg::FMT_J: d.op3 = cur_pc + imm_j;
      rv_decode_pkg::FMT_S: d.op3 = imm_s;
      rv_decode_pkg::FMT_I: d.op3 = is_jalr ? cur_pc + 64'd4 : (is_load ? imm_i : 64'd0);
      default: d.op3 = 64'd0;
    endcase
    return d;
  endfunction

  task automatic check_field(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    assert (actual === expected) else begin
      errors++;
      $display("Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic check_outputs();
    check_field("o_valid", valid, exp_valid);
    check_field("o_dec.rs1_ren", dec.rs1_ren, exp_dec.rs1_ren);
    check_field("o_dec.rs1", dec.rs1, exp_dec.rs1);
    check_field("o_dec.rs2_ren", dec.rs2_ren, exp_dec.rs2_ren);
    check_field("o_dec.rs2", dec.rs2, exp_dec.rs2);
    check_field("o_dec.rd_wen", dec.rd_wen, exp_dec.rd_wen);
    check_field("o_dec.rd", dec.rd, exp_dec.rd);
    check_field("o_dec.fmt", dec.fmt, exp_dec.fmt);
    check_field("o_dec.op1", dec.op1, exp_dec.op1);
    check_field("o_dec.op2", dec.op2, exp_dec.op2);
    check_field("o_dec.op3", dec.op3, exp_dec.op3);
    check_field("o_dec.skipcmt", dec.skipcmt, exp_dec.skipcmt);
  endtask

  // mostly kept opcodes, sometimes console, fence, ecall, mret or raw words
  task automatic drive_random(input logic force_idle);
    logic [31:0] sel;
    logic [31:0] word;
    sel  = next_random();
    word = next_random();
    if (sel[31:30] != 2'b00) begin
      word[6:0] = kept_opcode(next_random() % 12);
    end else begin
      case (sel[29:27])
        3'd0: word = `INST_PUTCH;
        3'd1: word = 32'h0000000f;
        3'd2: word = 32'h00000073;
        3'd3: word = 32'h30200073;
        default: word = word;
      endcase
    end
    inst     = word;
    pc       = {next_random(), next_random()};
    rs1_data = {next_random(), next_random()};
    rs2_data = {next_random(), next_random()};
    ena      = force_idle ? 1'b0 : (sel[26:25] != 2'b00);
    if (ena) begin
      exp_dec = model_decode(word, pc, rs1_data, rs2_data);
    end
    exp_valid = ena;
  endtask

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Errors: %0d, assertion failures: %0d, timeouts: 1", errors,
             i_decode_stage.i_decode_stage_assertions.fail_count);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    lcg_state = 64'd5;
    errors    = 0;
    clk       = 1'b0;
    rst       = 1'b1;
    ena       = 1'b0;
    inst      = '0;
    pc        = '0;
    rs1_data  = '0;
    rs2_data  = '0;
    exp_valid = 1'b0;
    exp_dec   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_outputs();
    // first cycle idle so the cleared bundle must hold
    for (int n = 0; n < NUM_INSTS; n++) begin
      drive_random(n == 0);
      @(negedge clk);
      check_outputs();
    end
    $display("Errors: %0d, assertion failures: %0d, timeouts: 0", errors,
             i_decode_stage.i_decode_stage_assertions.fail_count);
    if (errors == 0 && i_decode_stage.i_decode_stage_assertions.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- tests/decode_stage_assertions.sv
/* Decode stage assertions
   valid timing, reset state and index gating on the top level outputs */
`timescale 1ns/1ns

module decode_stage_assertions (
  input logic                       clk,
  input logic                       rst,
  input logic                       i_ena,
  input logic                       o_valid,
  input rv_decode_pkg::decode_out_t o_dec
);

  int fail_count = 0;

  // one cycle latency from the enable strobe
  valid_follows_ena: assert property (@(posedge clk)
    (!rst && !$past(rst)) |-> (o_valid == $past(i_ena)))
    else begin
      fail_count++;
      $error("o_valid does not follow i_ena by one cycle");
    end

  cleared_after_reset: assert property (@(posedge clk)
    $past(rst) |-> (!o_valid && o_dec == '0))
    else begin
      fail_count++;
      $error("outputs not cleared in the cycle after reset");
    end

  rs1_gated: assert property (@(posedge clk)
    !o_dec.rs1_ren |-> (o_dec.rs1 == '0))
    else begin
      fail_count++;
      $error("rs1 index nonzero while rs1_ren is low");
    end

  rs2_gated: assert property (@(posedge clk)
    !o_dec.rs2_ren |-> (o_dec.rs2 == '0))
    else begin
      fail_count++;
      $error("rs2 index nonzero while rs2_ren is low");
    end

  rd_gated: assert property (@(posedge clk)
    !o_dec.rd_wen |-> (o_dec.rd == '0))
    else begin
      fail_count++;
      $error("rd index nonzero while rd_wen is low");
    end

endmodule

bind decode_stage decode_stage_assertions i_decode_stage_assertions (
  .clk     (clk),
  .rst     (rst),
  .i_ena   (i_ena),
  .o_valid (o_valid),
  .o_dec   (o_dec)
);

//--- verilog/decode_stage.sv
/* Registered RV64 decode stage
   decodes one instruction per enabled cycle, one cycle latency */
`timescale 1ns/1ns

module decode_stage (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       i_ena,
  input  rv_decode_pkg::inst_t       i_inst,
  input  rv_decode_pkg::xlen_t       i_pc,
  input  rv_decode_pkg::xlen_t       i_rs1_data,
  input  rv_decode_pkg::xlen_t       i_rs2_data,
  output logic                       o_valid,
  output rv_decode_pkg::decode_out_t o_dec
);

  rv_decode_pkg::inst_fields_t fields;
  rv_decode_pkg::imm_set_t     imm;
  rv_decode_pkg::inst_class_t  iclass;
  logic                        skipcmt;
  rv_decode_pkg::decode_out_t  dec_next;

  inst_fields i_inst_fields (
    .i_inst   (i_inst),
    .o_fields (fields),
    .o_imm    (imm)
  );

  inst_classifier i_inst_classifier (
    .i_inst    (i_inst),
    .o_class   (iclass),
    .o_skipcmt (skipcmt)
  );

  operand_mux i_operand_mux (
    .i_fields   (fields),
    .i_imm      (imm),
    .i_class    (iclass),
    .i_skipcmt  (skipcmt),
    .i_pc       (i_pc),
    .i_rs1_data (i_rs1_data),
    .i_rs2_data (i_rs2_data),
    .o_dec      (dec_next)
  );

  // output bundle holds while i_ena is low
  always_ff @(posedge clk) begin
    if (rst) begin
      o_valid <= 1'b0;
      o_dec   <= '0;
    end else begin
      o_valid <= i_ena;
      if (i_ena) begin
        o_dec <= dec_next;
      end
    end
  end

endmodule

//--- verilog/operand_mux.sv
/* Operand select
   register enables and indices, op1/op2/op3 with branch and jump target adders */
`timescale 1ns/1ns
`include "rv_decode_macros.svh"

module operand_mux (
  input  rv_decode_pkg::inst_fields_t i_fields,
  input  rv_decode_pkg::imm_set_t     i_imm,
  input  rv_decode_pkg::inst_class_t  i_class,
  input  logic                        i_skipcmt,
  input  rv_decode_pkg::xlen_t        i_pc,
  input  rv_decode_pkg::xlen_t        i_rs1_data,
  input  rv_decode_pkg::xlen_t        i_rs2_data,
  output rv_decode_pkg::decode_out_t  o_dec
);

  logic                 is_r, is_i, is_s, is_b, is_u, is_j, is_csri;
  logic                 rs1_ren;
  logic                 rs2_ren;
  logic                 rd_wen;
  rv_decode_pkg::xlen_t br_target;
  rv_decode_pkg::xlen_t jal_target;
  rv_decode_pkg::xlen_t ret_addr;

  assign is_r    = (i_class.fmt == rv_decode_pkg::FMT_R);
  assign is_i    = (i_class.fmt == rv_decode_pkg::FMT_I);
  assign is_s    = (i_class.fmt == rv_decode_pkg::FMT_S);
  assign is_b    = (i_class.fmt == rv_decode_pkg::FMT_B);
  assign is_u    = (i_class.fmt == rv_decode_pkg::FMT_U);
  assign is_j    = (i_class.fmt == rv_decode_pkg::FMT_J);
  assign is_csri = (i_class.fmt == rv_decode_pkg::FMT_CSRI);

  assign rs1_ren = is_r | is_i | is_s | is_b;
  assign rs2_ren = is_r | is_s | is_b;
  assign rd_wen  = is_r | is_i | is_u | is_j | is_csri;

  // wrapping 64-bit adds
  assign br_target  = i_pc + i_imm.imm_b;
  assign jal_target = i_pc + i_imm.imm_j;
  assign ret_addr   = i_pc + `XLEN'd4;

  always_comb begin
    o_dec.rs1_ren = rs1_ren;
    o_dec.rs1     = rs1_ren ? i_fields.rs1 : '0;
    o_dec.rs2_ren = rs2_ren;
    o_dec.rs2     = rs2_ren ? i_fields.rs2 : '0;
    o_dec.rd_wen  = rd_wen;
    o_dec.rd      = rd_wen ? i_fields.rd : '0;
    o_dec.fmt     = i_class.fmt;
    o_dec.skipcmt = i_skipcmt;

    if (rs1_ren) o_dec.op1 = i_rs1_data;
    else if (is_u) o_dec.op1 = i_imm.imm_u;
    else if (is_j) o_dec.op1 = i_pc;
    else if (is_csri) o_dec.op1 = {{(`XLEN-`RIDX_W){1'b0}}, i_fields.rs1};
    else o_dec.op1 = '0;

    if (rs2_ren) o_dec.op2 = i_rs2_data;
    else if (is_j) o_dec.op2 = `XLEN'd4;
    else if (is_i && i_class.is_shift_imm) o_dec.op2 = {{(`XLEN-`SHAMT_W){1'b0}}, i_fields.shamt};
    else if (is_i) o_dec.op2 = i_imm.imm_i;
    else if (is_u) o_dec.op2 = i_pc;
    else o_dec.op2 = '0;

    // only loads carry is_mem inside the I group
    if (is_b) o_dec.op3 = br_target;
    else if (is_j) o_dec.op3 = jal_target;
    else if (is_s) o_dec.op3 = i_imm.imm_s;
    else if (is_i && i_class.is_jalr) o_dec.op3 = ret_addr;
    else if (is_i && i_class.is_mem) o_dec.op3 = i_imm.imm_i;
    else o_dec.op3 = '0;
  end

endmodule

//--- verilog/inst_classifier.sv
/* Instruction classifier
   recognizes RV64I and CSR instructions and reduces them to a format plus flags */
`timescale 1ns/1ns
`include "rv_decode_macros.svh"

module inst_classifier (
  input  rv_decode_pkg::inst_t       i_inst,
  output rv_decode_pkg::inst_class_t o_class,
  output logic                       o_skipcmt
);

  logic [`OPC_W-1:0] opcode;
  logic [2:0]        funct3;
  logic              f7_5;
  logic              op_op_imm;
  logic              op_op_imm32;
  logic              op_op;
  logic              op_op32;
  logic              op_system;
  logic              inst_branch;
  logic              inst_load;
  logic              inst_store;
  logic              inst_jalr;
  logic              inst_slli, inst_srli, inst_srai;
  logic              inst_slliw, inst_srliw, inst_sraiw;
  logic              inst_addiw;
  logic              inst_alu_imm;
  logic              inst_add, inst_sub, inst_srl, inst_sra;
  logic              inst_alu_reg;
  logic              inst_addw, inst_subw, inst_sllw, inst_srlw, inst_sraw;
  logic              inst_csr;
  logic              inst_csri;
  logic              shift_imm;
  logic              fmt_r;
  logic              fmt_i;

  assign opcode = i_inst[`OPC_W-1:0];
  assign funct3 = i_inst[`FUNCT3_LSB +: 3];
  assign f7_5   = i_inst[`FUNCT7_LSB + 5];

  assign op_op_imm   = (opcode == `OPC_OP_IMM);
  assign op_op_imm32 = (opcode == `OPC_OP_IMM32);
  assign op_op       = (opcode == `OPC_OP);
  assign op_op32     = (opcode == `OPC_OP32);
  assign op_system   = (opcode == `OPC_SYSTEM);

  // beq bne blt bge bltu bgeu
  assign inst_branch = (opcode == `OPC_BRANCH) & (funct3[2] | ~funct3[1]);
  // lb lh lw ld lbu lhu lwu
  assign inst_load   = (opcode == `OPC_LOAD) & (funct3 != 3'b111);
  // sb sh sw sd
  assign inst_store  = (opcode == `OPC_STORE) & ~funct3[2];
  assign inst_jalr   = (opcode == `OPC_JALR) & (funct3 == 3'b000);

  // funct7 bit 5 picks arithmetic right shift
  assign inst_slli  = op_op_imm & (funct3 == 3'b001);
  assign inst_srli  = op_op_imm & (funct3 == 3'b101) & ~f7_5;
  assign inst_srai  = op_op_imm & (funct3 == 3'b101) & f7_5;
  assign inst_slliw = op_op_imm32 & (funct3 == 3'b001);
  assign inst_srliw = op_op_imm32 & (funct3 == 3'b101) & ~f7_5;
  assign inst_sraiw = op_op_imm32 & (funct3 == 3'b101) & f7_5;
  assign inst_addiw = op_op_imm32 & (funct3 == 3'b000);
  // addi slti sltiu xori ori andi
  assign inst_alu_imm = op_op_imm & (funct3[1:0] != 2'b01);

  assign inst_add = op_op & (funct3 == 3'b000) & ~f7_5;
  assign inst_sub = op_op & (funct3 == 3'b000) & f7_5;
  assign inst_srl = op_op & (funct3 == 3'b101) & ~f7_5;
  assign inst_sra = op_op & (funct3 == 3'b101) & f7_5;
  // sll slt sltu xor or and
  assign inst_alu_reg = op_op & (funct3 != 3'b000) & (funct3 != 3'b101);

  assign inst_addw = op_op32 & (funct3 == 3'b000) & ~f7_5;
  assign inst_subw = op_op32 & (funct3 == 3'b000) & f7_5;
  assign inst_sllw = op_op32 & (funct3 == 3'b001);
  assign inst_srlw = op_op32 & (funct3 == 3'b101) & ~f7_5;
  assign inst_sraw = op_op32 & (funct3 == 3'b101) & f7_5;

  // funct3 2'b00 is ecall, ebreak, mret and friends
  assign inst_csr  = op_system & ~funct3[2] & (funct3[1:0] != 2'b00);
  assign inst_csri = op_system & funct3[2] & (funct3[1:0] != 2'b00);

  assign shift_imm = inst_slli | inst_srli | inst_srai |
                     inst_slliw | inst_srliw | inst_sraiw;

  assign fmt_r = inst_add | inst_sub | inst_srl | inst_sra | inst_alu_reg |
                 inst_addw | inst_subw | inst_sllw | inst_srlw | inst_sraw;
  assign fmt_i = inst_jalr | inst_load | inst_alu_imm | shift_imm | inst_addiw | inst_csr;

  always_comb begin
    if (fmt_r) o_class.fmt = rv_decode_pkg::FMT_R;
    else if (fmt_i) o_class.fmt = rv_decode_pkg::FMT_I;
    else if (inst_store) o_class.fmt = rv_decode_pkg::FMT_S;
    else if (inst_branch) o_class.fmt = rv_decode_pkg::FMT_B;
    else if (opcode == `OPC_LUI || opcode == `OPC_AUIPC) o_class.fmt = rv_decode_pkg::FMT_U;
    else if (opcode == `OPC_JAL) o_class.fmt = rv_decode_pkg::FMT_J;
    else if (inst_csri) o_class.fmt = rv_decode_pkg::FMT_CSRI;
    else o_class.fmt = rv_decode_pkg::FMT_NONE;
    o_class.is_jalr      = inst_jalr;
    o_class.is_mem       = inst_load | inst_store;
    o_class.is_shift_imm = shift_imm;
  end

  assign o_skipcmt = (i_inst == `INST_PUTCH);

endmodule

//--- verilog/inst_fields.sv
/* Instruction field extraction
   register indices, funct fields, shamt and the five sign-extended immediates */
`timescale 1ns/1ns
`include "rv_decode_macros.svh"

module inst_fields (
  input  rv_decode_pkg::inst_t        i_inst,
  output rv_decode_pkg::inst_fields_t o_fields,
  output rv_decode_pkg::imm_set_t     o_imm
);

  logic sign;

  assign sign = i_inst[`ILEN-1];

  always_comb begin
    o_fields.rs1    = i_inst[`RS1_LSB +: `RIDX_W];
    o_fields.rs2    = i_inst[`RS2_LSB +: `RIDX_W];
    o_fields.rd     = i_inst[`RD_LSB +: `RIDX_W];
    o_fields.funct3 = i_inst[`FUNCT3_LSB +: 3];
    o_fields.funct7 = i_inst[`FUNCT7_LSB +: 7];
    // rv64 shamt reaches into funct7 bit 0
    o_fields.shamt  = i_inst[`RS2_LSB +: `SHAMT_W];
  end

  always_comb begin
    o_imm.imm_i = {{(`XLEN-12){sign}}, i_inst[31:20]};
    o_imm.imm_s = {{(`XLEN-12){sign}}, i_inst[31:25], i_inst[11:7]};
    // branch offset, bit 0 implied zero
    o_imm.imm_b = {
      {(`XLEN-12){sign}},
      i_inst[7],
      i_inst[30:25],
      i_inst[11:8],
      1'b0
    };
    o_imm.imm_u = {{(`XLEN-32){sign}}, i_inst[31:12], 12'b0};
    o_imm.imm_j = {
      {(`XLEN-20){sign}},
      i_inst[19:12],
      i_inst[20],
      i_inst[30:21],
      1'b0
    };
  end

endmodule

//--- verilog/rv_decode_pkg.sv
/* Shared types of the RV64 decode stage */
`include "rv_decode_macros.svh"

package rv_decode_pkg;

  typedef logic [`XLEN-1:0]    xlen_t;
  typedef logic [`ILEN-1:0]    inst_t;
  typedef logic [`RIDX_W-1:0]  ridx_t;
  typedef logic [`SHAMT_W-1:0] shamt_t;

  typedef enum logic [2:0] {
    FMT_NONE,
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_B,
    FMT_U,
    FMT_J,
    FMT_CSRI
  } inst_fmt_e;

  typedef struct packed {
    ridx_t      rs1;
    ridx_t      rs2;
    ridx_t      rd;
    logic [2:0] funct3;
    logic [6:0] funct7;
    shamt_t     shamt;
  } inst_fields_t;

  typedef struct packed {
    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_b;
    xlen_t imm_u;
    xlen_t imm_j;
  } imm_set_t;

  typedef struct packed {
    inst_fmt_e fmt;
    logic      is_jalr;
    logic      is_mem;
    logic      is_shift_imm;
  } inst_class_t;

  typedef struct packed {
    logic      rs1_ren;
    ridx_t     rs1;
    logic      rs2_ren;
    ridx_t     rs2;
    logic      rd_wen;
    ridx_t     rd;
    inst_fmt_e fmt;
    xlen_t     op1;
    xlen_t     op2;
    xlen_t     op3;
    logic      skipcmt;
  } decode_out_t;

endpackage

//--- verilog/rv_decode_macros.svh
/* RV64 decode constants
   data widths, instruction field positions and major opcodes */
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

`define XLEN        64
`define ILEN        32
`define RIDX_W      5
`define SHAMT_W     6
`define OPC_W       7

// field lsb positions
`define RD_LSB      7
`define FUNCT3_LSB  12
`define RS1_LSB     15
`define RS2_LSB     20
`define FUNCT7_LSB  25

`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
`define OPC_BRANCH   7'b1100011
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011
`define OPC_OP_IMM   7'b0010011
`define OPC_OP       7'b0110011
`define OPC_OP_IMM32 7'b0011011
`define OPC_OP32     7'b0111011
`define OPC_SYSTEM   7'b1110011

// custom console putch, committed without difftest compare
`define INST_PUTCH   32'h0000007b

`endif
